// File: design/fdsu_defines.svh
// word, exponent and fraction widths, default quiet NaN patterns
`ifndef FDSU_DEFINES_SVH
`define FDSU_DEFINES_SVH

// register word width
`define FDSU_XLEN 64

// double precision fields
`define FDSU_D_EXP  11
`define FDSU_D_FRAC 52

// single precision fields
`define FDSU_S_EXP  8
`define FDSU_S_FRAC 23

// default quiet NaN, sign 0, exponent all ones, fraction msb set
`define FDSU_D_DQNAN 64'h7ff8_0000_0000_0000
// single default NaN, upper half boxed with ones
`define FDSU_S_DQNAN 64'hffff_ffff_7fc0_0000

`endif

// File: design/fdsu_fmt_pkg.sv
// operand format enum, operand word union and operand class struct
`include "fdsu_defines.svh"

package fdsu_fmt_pkg;

  // operand precision
  typedef enum logic
  {
    FMT_D = 1'b0,
    FMT_S = 1'b1
  } fp_fmt_e;

  // double view of a register word
  typedef struct packed
  {
    logic                     sign;
    logic [`FDSU_D_EXP-1:0]   exp;
    logic [`FDSU_D_FRAC-1:0]  frac;
  } fp_d_view_t;

  // single view, upper half holds the NaN box
  typedef struct packed
  {
    logic [`FDSU_XLEN-1-`FDSU_S_EXP-`FDSU_S_FRAC-1:0] box;
    logic                                            sign;
    logic [`FDSU_S_EXP-1:0]                          exp;
    logic [`FDSU_S_FRAC-1:0]                         frac;
  } fp_s_view_t;

  // one 64-bit word, decoded as double or as boxed single
  typedef union packed
  {
    fp_d_view_t d;
    fp_s_view_t s;
  } fp_word_u;

  // class of one operand
  // cnan is an unboxed single, always reported with qnan too
  typedef struct packed
  {
    logic zero;
    logic inf;
    logic snan;
    logic qnan;
    logic cnan;
    logic norm;
    logic sign;
  } op_class_t;

endpackage

// File: design/fdsu_op_pkg.sv
// request, special decision and response structs
`include "fdsu_defines.svh"

package fdsu_op_pkg;

  // one divide or sqrt operation, 132 bits
  typedef struct packed
  {
    logic                   div;
    logic                   sqrt;
    fdsu_fmt_pkg::fp_fmt_e  fmt;
    // carry NaN payloads instead of default NaN
    logic                   dqnan_mode;
    fdsu_fmt_pkg::fp_word_u oper0;
    fdsu_fmt_pkg::fp_word_u oper1;
  } fdsu_req_t;

  // source of the quiet NaN payload
  typedef enum logic [1:0]
  {
    QSEL_DEFAULT = 2'd0,
    QSEL_OP0     = 2'd1,
    QSEL_OP1     = 2'd2
  } qnan_sel_e;

  // decision of the special-case detector
  typedef struct packed
  {
    logic      nv;
    logic      dz;
    logic      result_zero;
    logic      result_inf;
    logic      result_qnan;
    qnan_sel_e qnan_sel;
    logic      result_sign;
    // special result, srt iteration not needed
    logic      srt_skip;
  } special_dec_t;

  // response back to the requester, 67 bits
  typedef struct packed
  {
    logic [`FDSU_XLEN-1:0] result;
    logic                  nv;
    logic                  dz;
    logic                  skip;
  } fdsu_rsp_t;

endpackage

// File: design/fdsu_operand_classify.sv
// operand classifier for double and NaN-boxed single words
`include "fdsu_defines.svh"

module fdsu_operand_classify (
  input  fdsu_fmt_pkg::fp_word_u  oper,
  input  fdsu_fmt_pkg::fp_fmt_e   fmt,
  output fdsu_fmt_pkg::op_class_t op_class
);

  logic boxed;
  logic sign;
  logic exp_max;
  logic exp_zero;
  logic frac_zero;
  logic frac_msb;

  // field decode through the view picked by fmt
  always_comb
  begin
    if (fmt == fdsu_fmt_pkg::FMT_S)
    begin
      // upper half must be all ones for a legal single
      boxed     = &oper.s.box;
      sign      = oper.s.sign;
      exp_max   = &oper.s.exp;
      exp_zero  = ~|oper.s.exp;
      frac_zero = ~|oper.s.frac;
      frac_msb  = oper.s.frac[`FDSU_S_FRAC-1];
    end
    else
    begin
      boxed     = 1'b1;
      sign      = oper.d.sign;
      exp_max   = &oper.d.exp;
      exp_zero  = ~|oper.d.exp;
      frac_zero = ~|oper.d.frac;
      frac_msb  = oper.d.frac[`FDSU_D_FRAC-1];
    end
  end

  // class flags
  always_comb
  begin
    op_class.cnan = !boxed;
    op_class.zero = boxed && exp_zero && frac_zero;
    op_class.inf  = boxed && exp_max && frac_zero;
    // fraction msb clear with nonzero fraction
    op_class.snan = boxed && exp_max && !frac_zero && !frac_msb;
    // unboxed words behave as quiet NaN
    op_class.qnan = !boxed || (exp_max && frac_msb);
    // denormals fall into norm
    op_class.norm = boxed && !exp_max && !(exp_zero && frac_zero);
    op_class.sign = sign;
  end

endmodule

// File: design/fdsu_special_detect.sv
// exception detection, special result decision and NaN source selection
module fdsu_special_detect (
  input  fdsu_op_pkg::fdsu_req_t    cap_req,
  input  fdsu_fmt_pkg::op_class_t   op0_class,
  input  fdsu_fmt_pkg::op_class_t   op1_class,
  output fdsu_op_pkg::special_dec_t dec
);

  logic div;
  logic sqrt;
  logic div_nv;
  logic sqrt_nv;
  logic nv;
  logic dz;
  logic div_rst_zero;
  logic div_rst_inf;
  logic div_rst_qnan;
  logic rst_zero;
  logic rst_inf;
  logic rst_qnan;
  logic rst_default_qnan;
  logic op1_is_snan;
  logic op1_is_qnan;
  fdsu_op_pkg::qnan_sel_e qnan_sel;

  assign div  = cap_req.div;
  assign sqrt = cap_req.sqrt;

  // ==========================================================================
  // exceptions
  // ==========================================================================

  // div nv: any snan, 0/0, inf/inf
  assign div_nv = op0_class.snan || op1_class.snan ||
                  (op0_class.zero && op1_class.zero) ||
                  (op0_class.inf && op1_class.inf);

  // sqrt nv: snan, or negative value that is not zero or NaN
  assign sqrt_nv = op0_class.snan ||
                   (op0_class.sign && (op0_class.norm || op0_class.inf));

  assign nv = (div && div_nv) || (sqrt && sqrt_nv);

  // normal over zero
  assign dz = div && op0_class.norm && op1_class.zero;

  // ==========================================================================
  // special result kind
  // ==========================================================================

  // zero over normal, or any finite over inf
  assign div_rst_zero = (op0_class.zero && op1_class.norm) ||
                        ((op0_class.zero || op0_class.norm) && op1_class.inf);
  // sqrt of zero keeps the zero
  assign rst_zero = (div && div_rst_zero) || (sqrt && op0_class.zero);

  // inf over finite
  assign div_rst_inf = op0_class.inf && (op1_class.zero || op1_class.norm);
  // sqrt of +inf, plus divide by zero
  assign rst_inf = (div && div_rst_inf) ||
                   (sqrt && op0_class.inf && !op0_class.sign) ||
                   dz;

  // any quiet NaN input, or an invalid operation
  assign div_rst_qnan = op0_class.qnan || op1_class.qnan;
  assign rst_qnan = (div && div_rst_qnan) || (sqrt && op0_class.qnan) || nv;

  // invalid cases without a NaN input always give the default NaN
  assign rst_default_qnan =
    (div && op0_class.zero && op1_class.zero) ||
    (div && op0_class.inf && op1_class.inf) ||
    (sqrt && op0_class.sign && (op0_class.norm || op0_class.inf));

  // ==========================================================================
  // NaN payload source
  // ==========================================================================

  // op1 only takes part in divide
  assign op1_is_snan = op1_class.snan && div;
  assign op1_is_qnan = op1_class.qnan && div;

  // signalling before quiet, op0 before op1
  always_comb
  begin
    if (!rst_qnan || rst_default_qnan || !cap_req.dqnan_mode)
      qnan_sel = fdsu_op_pkg::QSEL_DEFAULT;
    else if (op0_class.snan)
      qnan_sel = fdsu_op_pkg::QSEL_OP0;
    else if (op1_is_snan)
      qnan_sel = fdsu_op_pkg::QSEL_OP1;
    else if (op0_class.qnan)
      // unboxed single has no payload to carry
      qnan_sel = op0_class.cnan ? fdsu_op_pkg::QSEL_DEFAULT : fdsu_op_pkg::QSEL_OP0;
    else if (op1_is_qnan)
      qnan_sel = op1_class.cnan ? fdsu_op_pkg::QSEL_DEFAULT : fdsu_op_pkg::QSEL_OP1;
    else
      qnan_sel = fdsu_op_pkg::QSEL_DEFAULT;
  end

  // decision
  always_comb
  begin
    dec.nv          = nv;
    dec.dz          = dz;
    dec.result_zero = rst_zero;
    dec.result_inf  = rst_inf;
    dec.result_qnan = rst_qnan;
    dec.qnan_sel    = qnan_sel;
    // xor for divide, zero keeps its sign under sqrt, sqrt(+inf) is positive
    dec.result_sign = div ? (op0_class.sign ^ op1_class.sign)
                          : (op0_class.zero && op0_class.sign);
    dec.srt_skip    = rst_zero || rst_inf || rst_qnan;
  end

endmodule

// File: design/fdsu_special_result.sv
// special result word builder and response register
`include "fdsu_defines.svh"

module fdsu_special_result (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rsp_load,
  input  fdsu_op_pkg::fdsu_req_t    cap_req,
  input  fdsu_op_pkg::special_dec_t dec,
  output fdsu_op_pkg::fdsu_rsp_t    rsp
);

  fdsu_fmt_pkg::fp_word_u src;
  fdsu_fmt_pkg::fp_word_u word;

  // payload source for NaN propagation
  assign src = (dec.qnan_sel == fdsu_op_pkg::QSEL_OP1) ? cap_req.oper1 : cap_req.oper0;

  always_comb
  begin
    // non-special results stay zero for the srt datapath
    word = '0;
    if (cap_req.fmt == fdsu_fmt_pkg::FMT_S)
    begin
      if (dec.result_qnan && dec.qnan_sel == fdsu_op_pkg::QSEL_DEFAULT)
        word = `FDSU_S_DQNAN;
      else if (dec.result_qnan)
      begin
        // operand sign and fraction with the quiet bit forced
        word.s.box                    = '1;
        word.s.sign                   = src.s.sign;
        word.s.exp                    = '1;
        word.s.frac                   = src.s.frac;
        word.s.frac[`FDSU_S_FRAC-1]   = 1'b1;
      end
      else if (dec.result_inf || dec.result_zero)
      begin
        // boxed signed inf or zero
        word.s.box  = '1;
        word.s.sign = dec.result_sign;
        word.s.exp  = dec.result_inf ? '1 : '0;
        word.s.frac = '0;
      end
    end
    else
    begin
      if (dec.result_qnan && dec.qnan_sel == fdsu_op_pkg::QSEL_DEFAULT)
        word = `FDSU_D_DQNAN;
      else if (dec.result_qnan)
      begin
        word.d.sign                   = src.d.sign;
        word.d.exp                    = '1;
        word.d.frac                   = src.d.frac;
        word.d.frac[`FDSU_D_FRAC-1]   = 1'b1;
      end
      else if (dec.result_inf || dec.result_zero)
      begin
        word.d.sign = dec.result_sign;
        word.d.exp  = dec.result_inf ? '1 : '0;
        word.d.frac = '0;
      end
    end
  end

  // stage 2 response held until the next load
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rsp <= '0;
    else if (rsp_load)
    begin
      rsp.result <= word;
      rsp.nv     <= dec.nv;
      rsp.dz     <= dec.dz;
      rsp.skip   <= dec.srt_skip;
    end
  end

endmodule

// File: design/fdsu_special_ctrl.sv
// four-phase req/ack sequencer with request capture and load enable
module fdsu_special_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  fdsu_op_pkg::fdsu_req_t req_data,
  output logic                   ack,
  output fdsu_op_pkg::fdsu_req_t cap_req,
  output logic                   rsp_load
);

  typedef enum logic [1:0]
  {
    ST_IDLE     = 2'd0,
    ST_CAPTURE  = 2'd1,
    ST_RESPOND  = 2'd2,
    ST_WAIT_LOW = 2'd3
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // ==========================================================================
  // state machine
  // ==========================================================================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (req)
          state_d = ST_CAPTURE;
      // request sits in stage 1, response loads at the end
      ST_CAPTURE:
        state_d = ST_RESPOND;
      ST_RESPOND:
        state_d = ST_WAIT_LOW;
      // ack held until the requester lets go of req
      ST_WAIT_LOW:
        if (!req)
          state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // stage 1 capture while idle
  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE && req)
      cap_req <= req_data;
  end

  assign rsp_load = (state_q == ST_CAPTURE);
  assign ack      = (state_q == ST_WAIT_LOW);

endmodule

// File: design/fdsu_special_top.sv
// special-case front end top, controller, classifiers, detector, result stage
module fdsu_special_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  fdsu_op_pkg::fdsu_req_t req_data,
  output logic                   ack,
  output fdsu_op_pkg::fdsu_rsp_t rsp
);

  fdsu_op_pkg::fdsu_req_t    cap_req;
  logic                      rsp_load;
  fdsu_fmt_pkg::op_class_t   op0_class;
  fdsu_fmt_pkg::op_class_t   op1_class;
  fdsu_op_pkg::special_dec_t dec;

  // handshake and stage 1
  fdsu_special_ctrl fdsu_special_ctrl_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .cap_req  (cap_req),
    .rsp_load (rsp_load)
  );

  // one classifier per operand
  fdsu_operand_classify fdsu_op0_classify_inst (
    .oper     (cap_req.oper0),
    .fmt      (cap_req.fmt),
    .op_class (op0_class)
  );

  fdsu_operand_classify fdsu_op1_classify_inst (
    .oper     (cap_req.oper1),
    .fmt      (cap_req.fmt),
    .op_class (op1_class)
  );

  fdsu_special_detect fdsu_special_detect_inst (
    .cap_req   (cap_req),
    .op0_class (op0_class),
    .op1_class (op1_class),
    .dec       (dec)
  );

  // stage 2
  fdsu_special_result fdsu_special_result_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rsp_load (rsp_load),
    .cap_req  (cap_req),
    .dec      (dec),
    .rsp      (rsp)
  );

endmodule

// File: tests/tb_fdsu_checker.sv
// response checker: result and flag compare on ack rise, req/ack ordering checks
module tb_fdsu_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   ack,
  input  fdsu_op_pkg::fdsu_rsp_t rsp,
  input  fdsu_op_pkg::fdsu_rsp_t exp_rsp,
  input  int                     test_id,
  input  logic [8*16-1:0]        test_name,
  output int                     rows_checked,
  output int                     rows_failed,
  output int                     hs_errors
);
  timeunit 1ns;
  timeprecision 100ps;

  int   row_errors;
  // previous negedge samples
  logic ack_q;
  logic req_q;

  // one field compare, narrow flags zero extended
  task automatic compare_field(input string sig, input logic [63:0] expv,
                               input logic [63:0] actv);
    if (actv !== expv)
    begin
      $display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, sig, expv, actv);
      row_errors = row_errors + 1;
    end
  endtask

  // ==========================================================================
  // sampling on the falling edge, away from the driver and the DUT registers
  // ==========================================================================

  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      rows_checked = 0;
      rows_failed  = 0;
      hs_errors    = 0;
      ack_q        = 1'b0;
      req_q        = 1'b0;
    end
    else
    begin
      // ack rise, response valid from here on
      if (ack && !ack_q)
      begin
        if (!req_q)
        begin
          $display("handshake error at %0t ns: ack rose while req was low", $time);
          hs_errors = hs_errors + 1;
        end
        row_errors = 0;
        compare_field("rsp.result", exp_rsp.result, rsp.result);
        compare_field("rsp.nv", 64'(exp_rsp.nv), 64'(rsp.nv));
        compare_field("rsp.dz", 64'(exp_rsp.dz), 64'(rsp.dz));
        compare_field("rsp.skip", 64'(exp_rsp.skip), 64'(rsp.skip));
        rows_checked = rows_checked + 1;
        if (row_errors == 0)
          $display("row %0d %s: ok", test_id, test_name);
        else
        begin
          $display("row %0d %s: FAIL with %0d mismatches", test_id, test_name, row_errors);
          rows_failed = rows_failed + 1;
        end
      end
      // ack must not drop while req still high
      if (!ack && ack_q && req_q)
      begin
        $display("handshake error at %0t ns: ack fell before req was dropped", $time);
        hs_errors = hs_errors + 1;
      end
      ack_q = ack;
      req_q = req;
    end
  end

endmodule

// File: tests/tb_fdsu_special.sv
// testbench top with clock, reset, stimulus table, handshake driver and DUT
module tb_fdsu_special;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_TIMEOUT = 50;
  localparam int NUM_RANDOM  = 20;

  localparam logic DIV  = 1'b1;
  localparam logic SQRT = 1'b0;
  localparam fdsu_fmt_pkg::fp_fmt_e FD = fdsu_fmt_pkg::FMT_D;
  localparam fdsu_fmt_pkg::fp_fmt_e FS = fdsu_fmt_pkg::FMT_S;

  // double operands
  localparam logic [63:0] D_ONE   = 64'h3ff0000000000000;
  localparam logic [63:0] D_NONE  = 64'hbff0000000000000;
  localparam logic [63:0] D_TWO   = 64'h4000000000000000;
  localparam logic [63:0] D_PZERO = 64'h0000000000000000;
  localparam logic [63:0] D_NZERO = 64'h8000000000000000;
  localparam logic [63:0] D_PINF  = 64'h7ff0000000000000;
  localparam logic [63:0] D_NINF  = 64'hfff0000000000000;
  // negative sNaN and positive qNaN with payloads
  localparam logic [63:0] D_SNAN  = 64'hfff0000000001234;
  localparam logic [63:0] D_QNAN  = 64'h7ff8000000005678;
  // boxed single operands
  localparam logic [63:0] S_ONE   = 64'hffffffff3f800000;
  localparam logic [63:0] S_NONE  = 64'hffffffffbf800000;
  localparam logic [63:0] S_NTWO  = 64'hffffffffc0000000;
  localparam logic [63:0] S_PZERO = 64'hffffffff00000000;
  localparam logic [63:0] S_NZERO = 64'hffffffff80000000;
  localparam logic [63:0] S_PINF  = 64'hffffffff7f800000;
  localparam logic [63:0] S_NINF  = 64'hffffffffff800000;
  // 1.0 with a broken box
  localparam logic [63:0] S_UNBOX = 64'h000000003f800000;
  // default quiet NaNs
  localparam logic [63:0] D_DQNAN = 64'h7ff8000000000000;
  localparam logic [63:0] S_DQNAN = 64'hffffffff7fc00000;

  // one stimulus row with its expected response
  typedef struct packed
  {
    logic [8*16-1:0]        name;
    fdsu_op_pkg::fdsu_req_t req;
    fdsu_op_pkg::fdsu_rsp_t rsp;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req;
  logic                   ack;
  fdsu_op_pkg::fdsu_req_t req_data;
  fdsu_op_pkg::fdsu_rsp_t rsp;
  fdsu_op_pkg::fdsu_rsp_t exp_rsp;
  int                     test_id;
  logic [8*16-1:0]        test_name;
  int                     rows_checked;
  int                     rows_failed;
  int                     hs_errors;
  int                     timeouts;
  int                     seed;
  int                     idx;
  bit                     row_ok;
  row_t                   rows[$];

  fdsu_special_top fdsu_special_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

  tb_fdsu_checker checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .ack          (ack),
    .rsp          (rsp),
    .exp_rsp      (exp_rsp),
    .test_id      (test_id),
    .test_name    (test_name),
    .rows_checked (rows_checked),
    .rows_failed  (rows_failed),
    .hs_errors    (hs_errors)
  );

  // 4 ns clock
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // flags packed as {nv, dz, skip}
  function automatic void add_row(input logic [8*16-1:0] name, input logic is_div,
                                  input fdsu_fmt_pkg::fp_fmt_e fmt, input logic dq,
                                  input logic [63:0] op0, input logic [63:0] op1,
                                  input logic [63:0] result, input logic [2:0] flags);
    row_t row;
    row.name           = name;
    row.req.div        = is_div;
    row.req.sqrt       = !is_div;
    row.req.fmt        = fmt;
    row.req.dqnan_mode = dq;
    row.req.oper0      = op0;
    row.req.oper1      = op1;
    row.rsp.result     = result;
    {row.rsp.nv, row.rsp.dz, row.rsp.skip} = flags;
    rows.push_back(row);
  endfunction

  // random normal operand with the exponent kept off zero and all ones
  task automatic make_normal(input fdsu_fmt_pkg::fp_fmt_e fmt, input logic pos,
                             output logic [63:0] word);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    if (fmt == FS)
    begin
      word = {32'hffff_ffff, lo};
      if (word[30:23] == 8'h00)
        word[30:23] = 8'h01;
      else if (word[30:23] == 8'hff)
        word[30:23] = 8'hfe;
      if (pos)
        word[31] = 1'b0;
    end
    else
    begin
      word = {hi, lo};
      if (word[62:52] == 11'h000)
        word[62:52] = 11'h001;
      else if (word[62:52] == 11'h7ff)
        word[62:52] = 11'h7fe;
      if (pos)
        word[63] = 1'b0;
    end
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  task automatic build_table();
    int          r;
    logic [63:0] op0;
    logic [63:0] op1;
    // divide exceptions
    add_row("div 0/0", DIV, FD, 0, D_PZERO, D_PZERO, D_DQNAN, 3'b101);
    add_row("div inf/-inf", DIV, FD, 0, D_PINF, D_NINF, D_DQNAN, 3'b101);
    add_row("div snan/1", DIV, FD, 0, D_SNAN, D_ONE, D_DQNAN, 3'b101);
    add_row("div -1/0", DIV, FD, 0, D_NONE, D_PZERO, D_NINF, 3'b011);
    // divide special values in double then single
    add_row("div 0/2", DIV, FD, 0, D_PZERO, D_TWO, D_PZERO, 3'b001);
    add_row("div -1/inf", DIV, FD, 0, D_NONE, D_PINF, D_NZERO, 3'b001);
    add_row("div -inf/2", DIV, FD, 0, D_NINF, D_TWO, D_NINF, 3'b001);
    add_row("div s 0/-2", DIV, FS, 0, S_PZERO, S_NTWO, S_NZERO, 3'b001);
    add_row("div s 1/inf", DIV, FS, 0, S_ONE, S_PINF, S_PZERO, 3'b001);
    add_row("div s -inf/1", DIV, FS, 0, S_NINF, S_ONE, S_NINF, 3'b001);
    // square root ignores op1
    add_row("sqrt -1", SQRT, FD, 0, D_NONE, D_PZERO, D_DQNAN, 3'b101);
    add_row("sqrt -inf", SQRT, FD, 0, D_NINF, D_PZERO, D_DQNAN, 3'b101);
    add_row("sqrt -0", SQRT, FD, 0, D_NZERO, D_PZERO, D_NZERO, 3'b001);
    add_row("sqrt +inf", SQRT, FD, 0, D_PINF, D_PZERO, D_PINF, 3'b001);
    add_row("sqrt s -1", SQRT, FS, 0, S_NONE, S_PZERO, S_DQNAN, 3'b101);
    // NaN propagation where sNaN comes back quieted with its sign
    add_row("snan0 qnan1 dq", DIV, FD, 1, D_SNAN, D_QNAN, 64'hfff8000000001234, 3'b101);
    add_row("qnan1 dq", DIV, FD, 1, D_ONE, D_QNAN, 64'h7ff8000000005678, 3'b001);
    add_row("snan0 qnan1", DIV, FD, 0, D_SNAN, D_QNAN, D_DQNAN, 3'b101);
    add_row("qnan1", DIV, FD, 0, D_ONE, D_QNAN, D_DQNAN, 3'b001);
    // broken box never carries a payload
    add_row("unboxed op0 dq", DIV, FS, 1, S_UNBOX, S_ONE, S_DQNAN, 3'b001);
    add_row("unboxed op1 dq", DIV, FS, 1, S_ONE, S_UNBOX, S_DQNAN, 3'b001);
    add_row("div 1/2", DIV, FD, 0, D_ONE, D_TWO, 64'h0, 3'b000);
    // random normals go to the srt path with the sqrt operand kept positive
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      r = $random(seed);
      make_normal(fdsu_fmt_pkg::fp_fmt_e'(r[1]), !r[0], op0);
      make_normal(fdsu_fmt_pkg::fp_fmt_e'(r[1]), 1'b0, op1);
      add_row("random", r[0], fdsu_fmt_pkg::fp_fmt_e'(r[1]), r[2], op0, op1, 64'h0, 3'b000);
    end
  endtask

  // ==========================================================================
  // four-phase driver entered and left 1 ns after a rising edge
  // ==========================================================================

  task automatic run_row(input int n, output bit ok);
    int cnt;
    ok        = 1'b1;
    test_id   = n;
    test_name = rows[n].name;
    exp_rsp   = rows[n].rsp;
    req_data  = rows[n].req;
    req       = 1'b1;
    cnt       = 0;
    while (ack !== 1'b1 && cnt < ACK_TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cnt = cnt + 1;
    end
    if (ack !== 1'b1)
    begin
      $display("timeout: ack did not rise within %0d cycles on row %0d", ACK_TIMEOUT, n);
      ok = 1'b0;
    end
    else
    begin
      req = 1'b0;
      cnt = 0;
      while (ack !== 1'b0 && cnt < ACK_TIMEOUT)
      begin
        @(posedge clk);
        #1;
        cnt = cnt + 1;
      end
      if (ack !== 1'b0)
      begin
        $display("timeout: ack stayed high %0d cycles after req dropped on row %0d",
                 ACK_TIMEOUT, n);
        ok = 1'b0;
      end
    end
  endtask

  initial
  begin
    seed      = 59;
    rst_n     = 1'b0;
    req       = 1'b0;
    req_data  = '0;
    exp_rsp   = '0;
    test_id   = 0;
    test_name = '0;
    timeouts  = 0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (idx = 0; idx < rows.size(); idx++)
    begin
      run_row(idx, row_ok);
      if (!row_ok)
      begin
        timeouts = timeouts + 1;
        break;
      end
    end
    // let the checker see the last ack fall
    repeat (2) @(posedge clk);
    $display("rows checked %0d of %0d, failed %0d, handshake errors %0d, timeouts %0d",
             rows_checked, rows.size(), rows_failed, hs_errors, timeouts);
    if (rows_failed == 0 && hs_errors == 0 && timeouts == 0 && rows_checked == rows.size())
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+design
design/fdsu_fmt_pkg.sv
design/fdsu_op_pkg.sv
design/fdsu_operand_classify.sv
design/fdsu_special_detect.sv
design/fdsu_special_result.sv
design/fdsu_special_ctrl.sv
design/fdsu_special_top.sv
tests/tb_fdsu_checker.sv
tests/tb_fdsu_special.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0 --timescale 1ns/100ps
TOP       := tb_fdsu_special
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# pass only if the simulation prints the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
